/* Makefile */
VERILATOR  ?= verilator
TOP        := seq_tb
FILELIST   := magic_seq.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TESTS PASSED
FAIL_MSG   := TESTS FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without passing"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/seq_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "seq_defines.svh"

module seq_checker
    import seq_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset,
    input  wb_req_t                     wb_req,
    input  wb_rsp_t                     wb_rsp,
    input  wire  [`SEQ_SLOTS-1:0]       reprog,
    input  wire  [`SEQ_INIT_TASKS-1:0]  init_task,
    input  wire                         start_exec
);

    //////////////////////////////////////////////////
    // slave-side lines

    reprog_onehot: assert property (@(posedge clk) disable iff (!reset) $onehot0(reprog))
        else $error("reprog has more than one line high");

    init_task_onehot: assert property (@(posedge clk) disable iff (!reset) $onehot0(init_task))
        else $error("init_task has more than one task active");

    // single-cycle trigger
    start_exec_pulse: assert property (@(posedge clk) disable iff (!reset)
        start_exec |=> !start_exec)
        else $error("start_exec held for two cycles");

    //////////////////////////////////////////////////
    // bus

    ack_after_req: assert property (@(posedge clk) disable iff (!reset)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))  // no request, no ack
        else $error("ack without a request in the cycle before");

endmodule

`default_nettype wire

/* dv/seq_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "seq_defines.svh"

module seq_tb
    import seq_pkg::*;
();

    localparam int MAX_DLY  = 8;                          // slave response delay in cycles
    localparam int SLOT_CYC = 8 * MAX_DLY + 16;           // worst case for one slot
    localparam int RUN_CYC  = 6 * `SEQ_SLOTS * SLOT_CYC;  // four full runs plus two stopped ones
    localparam int BUS_CYC  = 160 * 4;                    // about 160 accesses of 4 cycles
    localparam int LIMIT    = 8 * (RUN_CYC + BUS_CYC);    // generous margin

    logic                       clk;
    logic                       reset;
    wb_req_t                    wb_req;
    wb_rsp_t                    wb_rsp;
    logic [`SEQ_SLOTS-1:0]      reprog;
    logic                       nslave_reset;
    logic [`SEQ_INIT_TASKS-1:0] init_task;
    logic [`SEQ_INIT_TASKS-1:0] init_done;
    logic                       start_exec;
    logic                       exec_done;
    slot_t                      slot;

    slot_t model [`SEQ_SLOTS];     // expected slot table
    int    run_id;                 // bumped by each START
    int    hold_slot;              // slot whose exec_done is held back (-1 for none)
    logic  hold_en;
    int    last_run;               // responder side bookkeeping
    int    exp_slot;
    int    passes;
    int    exp_starts;
    logic  resp_busy;
    logic  held;
    int    starts_seen = 0;
    int    cycles = 0;

    seq_tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    seq_top u_seq_top (
        .clk          (clk),
        .reset        (reset),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .reprog       (reprog),
        .nslave_reset (nslave_reset),
        .init_task    (init_task),
        .init_done    (init_done),
        .start_exec   (start_exec),
        .exec_done    (exec_done),
        .slot         (slot)
    );

    bind seq_top seq_checker u_seq_checker (
        .clk        (clk),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .reprog     (reprog),
        .init_task  (init_task),
        .start_exec (start_exec)
    );

    //////////////////////////////////////////////////
    // helpers

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s, got %h expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic int rnd(input int lo, input int hi);
        return int'($urandom_range(hi, lo));
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic logic [7:0] slot_adr(input int idx, input int fld);
        return {1'b1, idx[1:0], fld[2:0], 2'b00};   // slot region, index, field
    endfunction

    function automatic logic [31:0] status_word(input logic [2:0] st, input logic [1:0] cnt,
                                                input logic [1:0] endc);
        logic [31:0] w;
        w        = '0;
        w[2:0]   = st;
        w[9:8]   = cnt;
        w[17:16] = endc;
        return w;
    endfunction

    function automatic logic [31:0] field_of(input slot_t s, input int fld);
        case (fld)
            0:       return s.src_addr;
            1:       return 32'(s.src_size);      // zero-extended
            2:       return s.dst_addr;
            3:       return 32'(s.dst_size);
            default: return s.profile;
        endcase
    endfunction

    task automatic model_write(input int idx, input int fld, input logic [31:0] d);
        case (fld)
            0:       model[idx].src_addr = d;
            1:       model[idx].src_size = d[`SEQ_SIZE_W-1:0];  // top bits dropped
            2:       model[idx].dst_addr = d;
            3:       model[idx].dst_size = d[`SEQ_SIZE_W-1:0];
            default: model[idx].profile  = d;
        endcase
    endtask

    //////////////////////////////////////////////////
    // wishbone master called on a falling edge

    task automatic bus(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                       output logic [31:0] rdat);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = wdat;
        do begin
            @(negedge clk);
        end while (!wb_rsp.ack);                 // hold until acked
        rdat   = wb_rsp.dat_r;
        wb_req = '0;
        @(negedge clk);                          // stb low for a cycle
    endtask

    task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] ignored;
        bus(1'b1, adr, dat, ignored);
    endtask

    task automatic bus_read_check(input logic [7:0] adr, input logic [31:0] exp, input string what);
        logic [31:0] dat;
        bus(1'b0, adr, '0, dat);
        check(dat, exp, what);
    endtask

    task automatic table_check();
        for (int i = 0; i < `SEQ_SLOTS; i++) begin
            for (int f = 0; f < 5; f++) begin
                bus_read_check(slot_adr(i, f), field_of(model[i], f),
                               $sformatf("slot %0d field %0d readback", i, f));
            end
        end
    endtask

    //////////////////////////////////////////////////
    // slave responder with one call per reprog pulse

    task automatic serve_slot();
        if (run_id != last_run) begin    // fresh run starts at slot 0
            exp_slot = 0;
            last_run = run_id;
        end
        check(32'(reprog), 32'(1) << exp_slot, "reprog line");
        for (int f = 0; f < 5; f++) begin
            check(field_of(slot, f), field_of(model[exp_slot], f),
                  $sformatf("descriptor slot %0d field %0d", exp_slot, f));
        end
        resp_busy = 1'b1;
        idle(rnd(0, MAX_DLY));
        nslave_reset = 1'b0;
        idle(rnd(2, MAX_DLY));           // low across two edges at least
        nslave_reset = 1'b1;
        for (int k = 0; k < `SEQ_INIT_TASKS; k++) begin
            while (init_task == '0) begin
                @(negedge clk);
            end
            check(32'(init_task), 32'(1) << k, "init_task step");
            idle(rnd(0, MAX_DLY));
            init_done = `SEQ_INIT_TASKS'(1) << k;
            @(negedge clk);
            init_done = '0;
        end
        check(32'(start_exec), 32'd1, "start_exec after last init done");
        exp_starts++;
        idle(rnd(1, MAX_DLY));           // wait_fin is entered by now
        while (hold_en && exp_slot == hold_slot) begin
            held = 1'b1;
            @(negedge clk);
        end
        held      = 1'b0;
        exec_done = 1'b1;
        @(negedge clk);
        exec_done = 1'b0;
        exp_slot++;
        passes++;
        resp_busy = 1'b0;
    endtask

    initial begin
        nslave_reset = 1'b1;
        init_done    = '0;
        exec_done    = 1'b0;
        last_run     = 0;
        exp_slot     = 0;
        passes       = 0;
        exp_starts   = 0;
        resp_busy    = 1'b0;
        held         = 1'b0;
        @(posedge reset);
        forever begin
            @(negedge clk);
            while (reprog != '0) begin
                serve_slot();
            end
        end
    end

    //////////////////////////////////////////////////
    // runs

    task automatic start_run();
        run_id++;
        bus_write(`SEQ_REG_CTRL, 32'(CMD_START));
    endtask

    task automatic full_run(input logic [1:0] endc);
        int base;
        bus_write(`SEQ_REG_END_CNT, 32'(endc));
        bus_read_check(`SEQ_REG_END_CNT, 32'(endc), "end count readback");
        base = passes;
        start_run();
        while (passes != base + int'(endc) + 1 || resp_busy) begin
            @(negedge clk);
        end
        bus_read_check(`SEQ_REG_STATUS, status_word(ST_SHUTDOWN, 2'd0, endc), "status after run");
        for (int i = 0; i <= int'(endc); i++) begin
            model[i].profile = model[i].profile + 1;   // one count per visit
        end
    endtask

    // stalls in wait_fin of slot hold_at, pokes the bus, then stops the run
    task automatic stopped_run(input int hold_at, input seq_cmd_e stop_cmd);
        logic [7:0] adr;
        logic [1:0] cnt_after;
        adr       = slot_adr(hold_at, 0);
        cnt_after = (stop_cmd == CMD_CLEAR) ? 2'd0 : 2'(hold_at);
        bus_write(`SEQ_REG_END_CNT, 32'd3);
        hold_slot = hold_at;
        hold_en   = 1'b1;
        start_run();
        while (!held) begin
            @(negedge clk);
        end
        bus_write(adr, ~field_of(model[hold_at], 0));          // table locked
        bus_read_check(adr, 32'd0, "slot read while running");
        bus_write(`SEQ_REG_END_CNT, 32'd1);
        bus_read_check(`SEQ_REG_END_CNT, 32'd3, "end count write while running");
        bus_write(`SEQ_REG_CTRL, 32'(CMD_START));
        bus_read_check(`SEQ_REG_STATUS, status_word(ST_WAIT_FIN, 2'(hold_at), 2'd3),
                       "start while running");
        bus_write(`SEQ_REG_CTRL, 32'(stop_cmd));
        bus_read_check(`SEQ_REG_STATUS, status_word(ST_SHUTDOWN, cnt_after, 2'd3),
                       "status after stop command");
        hold_en = 1'b0;                  // late exec_done lands in shutdown
        while (resp_busy) begin
            @(negedge clk);
        end
        hold_slot = -1;
        for (int i = 0; i <= hold_at; i++) begin
            model[i].profile = model[i].profile + 1;
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        logic [31:0] d;
        void'($urandom(32'h759e_7cd0));
        wb_req    = '0;
        run_id    = 0;
        hold_slot = -1;
        hold_en   = 1'b0;
        for (int i = 0; i < `SEQ_SLOTS; i++) begin
            model[i] = '0;
        end
        @(posedge reset);
        @(negedge clk);

        // random table fill in shutdown
        for (int i = 0; i < `SEQ_SLOTS; i++) begin
            for (int f = 0; f < 5; f++) begin
                d = $urandom();
                bus_write(slot_adr(i, f), d);
                model_write(i, f, d);
            end
        end
        table_check();

        repeat (4) begin
            full_run(2'($urandom_range(3, 0)));
            table_check();
        end

        stopped_run(1, CMD_SHUTDOWN);    // counter kept
        stopped_run(2, CMD_CLEAR);       // counter cleared
        table_check();
        check(32'(starts_seen), 32'(exp_starts), "start_exec pulse count");

        $display("TESTS PASSED");
        $finish;
    end

    //////////////////////////////////////////////////
    // monitors

    always @(negedge clk) begin
        if (start_exec) begin
            starts_seen <= starts_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("TESTS FAILED");
            $fatal(1, "simulation hung");
        end
    end

endmodule

`default_nettype wire

/* dv/seq_tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module seq_tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b0;               // active low, held for two cycles
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
    end

    always #10 clk = ~clk;          // 20 ns period

endmodule

`default_nettype wire

/* magic_seq.f */
+incdir+source
source/seq_pkg.sv
source/seq_wb_regs.sv
source/seq_slot_table.sv
source/seq_control_fsm.sv
source/seq_top.sv
dv/seq_tb_clock.sv
dv/seq_checker.sv
dv/seq_tb.sv

/* source/seq_control_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

`include "seq_defines.svh"

module seq_control_fsm
    import seq_pkg::*;
(
    input  wire                              clk,
    input  wire                              reset,
    input  seq_cmd_t                         cmd,
    input  wire        [`SEQ_SLOT_IDX_W-1:0] end_cnt,
    output seq_state_e                       state,
    output logic       [`SEQ_SLOT_IDX_W-1:0] slot_cnt,
    output logic                             profile_bump,
    output logic       [`SEQ_SLOTS-1:0]      reprog,
    input  wire                              nslave_reset,  // active low from the dfx side
    output logic       [`SEQ_INIT_TASKS-1:0] init_task,
    input  wire        [`SEQ_INIT_TASKS-1:0] init_done,
    output logic                             start_exec,
    input  wire                              exec_done
);

    logic cmd_clear;
    logic cmd_shutdown;
    logic cmd_start;

    assign cmd_clear    = cmd.valid && (cmd.code == CMD_CLEAR);
    assign cmd_shutdown = cmd.valid && (cmd.code == CMD_SHUTDOWN);
    assign cmd_start    = cmd.valid && (cmd.code == CMD_START) && (state == ST_SHUTDOWN);

    //////////////////////////////////////////////////
    // slave-side outputs decoded from state

    assign reprog       = (state == ST_REPROG) ? (`SEQ_SLOTS'(1) << slot_cnt) : '0;
    assign profile_bump = (state == ST_REPROG);     // lands at the closing edge
    assign start_exec   = (state == ST_TRIGGERING); // one cycle pulse

    //////////////////////////////////////////////////
    // sequencer

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= ST_SHUTDOWN;
            slot_cnt  <= '0;
            init_task <= '0;
        end else if (cmd_clear) begin
            state     <= ST_SHUTDOWN;
            slot_cnt  <= '0;
            init_task <= '0;
        end else if (cmd_shutdown) begin
            state <= ST_SHUTDOWN;   // counter and tasks kept as they are
        end else if (cmd_start) begin
            state     <= ST_REPROG;
            slot_cnt  <= '0;        // every run starts at slot 0
            init_task <= '0;
        end else begin
            case (state)
                ST_SHUTDOWN: begin
                    // idle until START
                end
                ST_REPROG: begin
                    state <= ST_WAIT_SLAVE_RESET;
                end
                ST_WAIT_SLAVE_RESET: begin
                    if (!nslave_reset) begin // module went into reset
                        state <= ST_WAIT_SLAVE_OP;
                    end
                end
                ST_WAIT_SLAVE_OP: begin
                    if (nslave_reset) begin  // module is back up
                        state     <= ST_INITIALIZING;
                        init_task <= `SEQ_INIT_TASKS'(1);
                    end
                end
                ST_INITIALIZING: begin
                    if (init_done[`SEQ_INIT_TASKS-1]) begin
                        state     <= ST_TRIGGERING; // last task done
                        init_task <= '0;
                    end else if (init_done != '0) begin
                        init_task <= init_task << 1; // next task
                    end
                end
                ST_TRIGGERING: begin
                    state <= ST_WAIT_FIN;
                end
                ST_WAIT_FIN: begin
                    if (exec_done) begin
                        if (slot_cnt < end_cnt) begin
                            slot_cnt <= slot_cnt + 1'b1;
                            state    <= ST_REPROG;
                        end else begin
                            slot_cnt <= '0;  // run complete
                            state    <= ST_SHUTDOWN;
                        end
                    end
                end
                default: begin
                    state <= ST_SHUTDOWN;   // unused code 7
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/seq_defines.svh */
`ifndef SEQ_DEFINES_SVH
`define SEQ_DEFINES_SVH

// slot table geometry
`define SEQ_SLOT_IDX_W    2    // slot index width
`define SEQ_SLOTS         4    // one reprogram line per slot
`define SEQ_ADDR_W        32   // transfer address
`define SEQ_SIZE_W        26   // transfer size, zero-extended on the bus
`define SEQ_PROFILE_W     32   // per-slot run counter

// dma init tasks stepped per slot
`define SEQ_INIT_TASKS    4

// wishbone classic slave
`define SEQ_WB_ADR_W      8    // byte address
`define SEQ_WB_DAT_W      32

// register map
`define SEQ_REG_CTRL      8'h00
`define SEQ_REG_STATUS    8'h04
`define SEQ_REG_END_CNT   8'h08
`define SEQ_SLOT_BASE_BIT 7    // set for the slot region
`define SEQ_SLOT_IDX_LSB  5    // adr[6:5] picks the slot
`define SEQ_SLOT_FLD_LSB  2    // adr[4:2] picks the field

`endif

/* source/seq_pkg.sv */
`default_nettype none

package seq_pkg;

`include "seq_defines.svh"

    // sequencer state, code shows up in STATUS[2:0]
    typedef enum logic [2:0] {
        ST_SHUTDOWN         = 3'd0,
        ST_REPROG           = 3'd1,
        ST_WAIT_SLAVE_RESET = 3'd2, // waiting for nslave_reset to fall
        ST_WAIT_SLAVE_OP    = 3'd3, // waiting for nslave_reset to rise
        ST_INITIALIZING     = 3'd4,
        ST_TRIGGERING       = 3'd5,
        ST_WAIT_FIN         = 3'd6
    } seq_state_e;

    typedef enum logic [1:0] {
        CMD_CLEAR    = 2'd0,
        CMD_SHUTDOWN = 2'd1,
        CMD_START    = 2'd2         // code 3 has no meaning
    } seq_cmd_e;

    typedef enum logic [2:0] {
        FLD_SRC_ADDR = 3'd0,
        FLD_SRC_SIZE = 3'd1,
        FLD_DST_ADDR = 3'd2,
        FLD_DST_SIZE = 3'd3,
        FLD_PROFILE  = 3'd4
    } slot_field_e;

    // one slot descriptor, 148 bits
    typedef struct packed {
        logic [`SEQ_ADDR_W-1:0]    src_addr;
        logic [`SEQ_SIZE_W-1:0]    src_size;
        logic [`SEQ_ADDR_W-1:0]    dst_addr;
        logic [`SEQ_SIZE_W-1:0]    dst_size;
        logic [`SEQ_PROFILE_W-1:0] profile;
    } slot_t;

    typedef struct packed {
        logic                       valid;
        logic [`SEQ_SLOT_IDX_W-1:0] idx;
        slot_field_e                field;
        logic [`SEQ_WB_DAT_W-1:0]   data;
    } slot_wr_t;

    typedef struct packed {
        logic     valid;
        seq_cmd_e code;
    } seq_cmd_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`SEQ_WB_ADR_W-1:0] adr;
        logic [`SEQ_WB_DAT_W-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        logic [`SEQ_WB_DAT_W-1:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* source/seq_slot_table.sv */
`timescale 1ns/100ps
`default_nettype none

`include "seq_defines.svh"

module seq_slot_table
    import seq_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  slot_wr_t                   slot_wr,
    input  wire  [`SEQ_SLOT_IDX_W-1:0] host_idx,
    output slot_t                      host_slot,
    input  wire  [`SEQ_SLOT_IDX_W-1:0] seq_idx,
    output slot_t                      seq_slot,
    input  wire                        profile_bump
);

    slot_t slots [`SEQ_SLOTS];  // the descriptor store

    //////////////////////////////////////////////////
    // read ports, both combinational

    assign host_slot = slots[host_idx];    // bus side
    assign seq_slot  = slots[seq_idx];     // sequencer side, drives the descriptor

    //////////////////////////////////////////////////
    // host field writes and profile bump

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `SEQ_SLOTS; i++) begin
                slots[i] <= '0;
            end
        end else begin
            if (slot_wr.valid) begin
                case (slot_wr.field)
                    FLD_SRC_ADDR: begin
                        slots[slot_wr.idx].src_addr <= slot_wr.data;
                    end
                    FLD_SRC_SIZE: begin
                        // upper bits of the bus word are dropped
                        slots[slot_wr.idx].src_size <= slot_wr.data[`SEQ_SIZE_W-1:0];
                    end
                    FLD_DST_ADDR: begin
                        slots[slot_wr.idx].dst_addr <= slot_wr.data;
                    end
                    FLD_DST_SIZE: begin
                        slots[slot_wr.idx].dst_size <= slot_wr.data[`SEQ_SIZE_W-1:0];
                    end
                    FLD_PROFILE: begin
                        slots[slot_wr.idx].profile <= slot_wr.data;
                    end
                    default: begin
                        // unused field codes
                    end
                endcase
            end

            // one count per reprogram of this slot
            if (profile_bump) begin
                slots[seq_idx].profile <= slots[seq_idx].profile + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/seq_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "seq_defines.svh"

module seq_top
    import seq_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset,
    // host side
    input  wb_req_t                     wb_req,
    output wb_rsp_t                     wb_rsp,
    // reconfiguration controller
    output logic  [`SEQ_SLOTS-1:0]      reprog,
    input  wire                         nslave_reset,
    // dma side
    output logic  [`SEQ_INIT_TASKS-1:0] init_task,
    input  wire   [`SEQ_INIT_TASKS-1:0] init_done,
    output logic                        start_exec,
    input  wire                         exec_done,
    output slot_t                       slot          // current slot descriptor
);

    //////////////////////////////////////////////////
    // internal nets

    seq_state_e                 state;
    logic [`SEQ_SLOT_IDX_W-1:0] slot_cnt;
    logic [`SEQ_SLOT_IDX_W-1:0] end_cnt;
    logic [`SEQ_SLOT_IDX_W-1:0] host_idx;
    slot_t                      host_slot;
    slot_wr_t                   slot_wr;
    seq_cmd_t                   cmd;
    logic                       profile_bump;

    seq_wb_regs u_seq_wb_regs (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .state     (state),
        .slot_cnt  (slot_cnt),
        .host_slot (host_slot),
        .host_idx  (host_idx),
        .slot_wr   (slot_wr),
        .cmd       (cmd),
        .end_cnt   (end_cnt)
    );

    seq_slot_table u_seq_slot_table (
        .clk          (clk),
        .reset        (reset),
        .slot_wr      (slot_wr),
        .host_idx     (host_idx),
        .host_slot    (host_slot),
        .seq_idx      (slot_cnt),  // sequencer reads the counter's slot
        .seq_slot     (slot),
        .profile_bump (profile_bump)
    );

    seq_control_fsm u_seq_control_fsm (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd),
        .end_cnt      (end_cnt),
        .state        (state),
        .slot_cnt     (slot_cnt),
        .profile_bump (profile_bump),
        .reprog       (reprog),
        .nslave_reset (nslave_reset),
        .init_task    (init_task),
        .init_done    (init_done),
        .start_exec   (start_exec),
        .exec_done    (exec_done)
    );

endmodule

`default_nettype wire

/* source/seq_wb_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "seq_defines.svh"

module seq_wb_regs
    import seq_pkg::*;
(
    input  wire                              clk,
    input  wire                              reset,
    input  wb_req_t                          wb_req,
    output wb_rsp_t                          wb_rsp,
    input  seq_state_e                       state,
    input  wire        [`SEQ_SLOT_IDX_W-1:0] slot_cnt,
    input  slot_t                            host_slot,
    output logic       [`SEQ_SLOT_IDX_W-1:0] host_idx,
    output slot_wr_t                         slot_wr,
    output seq_cmd_t                         cmd,
    output logic       [`SEQ_SLOT_IDX_W-1:0] end_cnt
);

    logic                     req;          // new cycle on the bus
    logic                     pend;         // request sampled, wait state
    logic                     go;           // decode edge, ack follows
    logic                     ack_q;
    logic [`SEQ_WB_DAT_W-1:0] dat_q;
    logic                     is_slot;
    logic                     is_ctrl;
    logic                     is_status;
    logic                     is_end_cnt;
    logic                     in_shutdown;
    slot_field_e              fld;
    logic [`SEQ_WB_DAT_W-1:0] rd_data;

    //////////////////////////////////////////////////
    // handshake

    assign req = wb_req.cyc && wb_req.stb && !ack_q;
    assign go  = pend && wb_req.cyc && wb_req.stb; // master still holds the request

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_q;

    //////////////////////////////////////////////////
    // address decode

    assign is_slot     = wb_req.adr[`SEQ_SLOT_BASE_BIT];
    assign is_ctrl     = (wb_req.adr == `SEQ_REG_CTRL);
    assign is_status   = (wb_req.adr == `SEQ_REG_STATUS);
    assign is_end_cnt  = (wb_req.adr == `SEQ_REG_END_CNT);
    assign in_shutdown = (state == ST_SHUTDOWN);

    assign host_idx = wb_req.adr[`SEQ_SLOT_IDX_LSB +: `SEQ_SLOT_IDX_W];
    assign fld      = slot_field_e'(wb_req.adr[`SEQ_SLOT_FLD_LSB +: $bits(slot_field_e)]);

    // read mux, anything unmapped stays zero
    always_comb begin
        rd_data = '0;
        if (is_slot) begin
            if (in_shutdown) begin // table is hidden while running
                case (fld)
                    FLD_SRC_ADDR: rd_data = host_slot.src_addr;
                    FLD_SRC_SIZE: rd_data = `SEQ_WB_DAT_W'(host_slot.src_size);
                    FLD_DST_ADDR: rd_data = host_slot.dst_addr;
                    FLD_DST_SIZE: rd_data = `SEQ_WB_DAT_W'(host_slot.dst_size);
                    FLD_PROFILE:  rd_data = host_slot.profile;
                    default:      rd_data = '0;
                endcase
            end
        end else if (is_status) begin
            rd_data[2:0]                    = state;
            rd_data[8 +: `SEQ_SLOT_IDX_W]   = slot_cnt;
            rd_data[16 +: `SEQ_SLOT_IDX_W]  = end_cnt;
        end else if (is_end_cnt) begin
            rd_data[`SEQ_SLOT_IDX_W-1:0] = end_cnt;
        end
    end

    //////////////////////////////////////////////////
    // ack, strobes and end count

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pend    <= 1'b0;
            ack_q   <= 1'b0;
            cmd     <= '0;
            slot_wr <= '0;
            end_cnt <= '0;
        end else begin
            pend  <= req && !pend;          // one wait state
            ack_q <= go;                    // single-cycle ack

            // command strobe lives in the ack cycle only
            cmd.valid <= go && wb_req.we && is_ctrl;
            cmd.code  <= seq_cmd_e'(wb_req.dat_w[$bits(seq_cmd_e)-1:0]);

            // slot writes pass only in shutdown, else acked and dropped
            slot_wr.valid <= go && wb_req.we && is_slot && in_shutdown;
            slot_wr.idx   <= host_idx;
            slot_wr.field <= fld;
            slot_wr.data  <= wb_req.dat_w;

            if (go && wb_req.we && is_end_cnt && in_shutdown) begin
                end_cnt <= wb_req.dat_w[`SEQ_SLOT_IDX_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            dat_q <= wb_req.we ? '0 : rd_data; // writes return zero
        end
    end

endmodule

`default_nettype wire
